/* compile.f */
+incdir+verif
common/post_pkg.sv
control/post_ctrl.sv
design/bias_cache.sv
pipeline/post_pipeline.sv
design/out_fifo.sv
design/post_process_top.sv
verif/tb_post_process.sv

/* Makefile */
TOP = tb_post_process

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f compile.f -o V$(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^Done: no errors$$'

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* verif/post_model.svh */
`ifndef post_model_svh
`define post_model_svh

// input beats in one frame, img_h lines per block
function automatic int frame_beats(input post_pkg::cfg_word_t w1, input post_pkg::cfg_word_t w2);
	int w, h, chout, blocks;
	w = int'(w1[post_pkg::img_w_lsb +: post_pkg::dim_w]);
	h = int'(w1[post_pkg::img_h_lsb +: post_pkg::dim_w]);
	chout = int'(w2[post_pkg::chout_len_lsb +: post_pkg::len_w]);
	blocks = int'(w2[post_pkg::total_len_lsb +: post_pkg::len_w]);
	return w * (chout / post_pkg::lanes) * h * blocks;
endfunction

// pixel fastest, then channel group, then line, then block
function automatic void walk_pos(input post_pkg::cfg_word_t w0, input post_pkg::cfg_word_t w1,
		input post_pkg::cfg_word_t w2, input int k, output int pix, output int line,
		output int ch);
	int rf, w, h, chout, per_line, per_blk, r;
	rf = int'(w0[post_pkg::row_filter_bit]);
	w = int'(w1[post_pkg::img_w_lsb +: post_pkg::dim_w]);
	h = int'(w1[post_pkg::img_h_lsb +: post_pkg::dim_w]);
	chout = int'(w2[post_pkg::chout_len_lsb +: post_pkg::len_w]);
	per_line = w * (chout / post_pkg::lanes);
	per_blk = per_line * h;
	r = k % per_blk;
	pix = r % w;
	line = r / per_line - rf; // -1 is the discarded line
	ch = (k / per_blk) * chout + ((r % per_line) / w) * post_pkg::lanes;
endfunction

// returns 0 when the beat yields no output
function automatic bit expect_beat(input post_pkg::cfg_word_t w0,
		input post_pkg::lane_t bias [post_pkg::bias_depth], input post_pkg::beat_t din,
		input int pix, input int line, input int ch, output post_pkg::beat_t dout);
	post_pkg::lane_t sum;
	int v, b, step, kept;
	step = 1 << post_pkg::relu_shift;
	kept = post_pkg::narrow_msb - post_pkg::narrow_lsb + 1;
	dout = '0;
	if (line < 0)
		return 1'b0;
	if (w0[post_pkg::sample_en_bit] && (pix % 2 != 0 || line % 2 != 0))
		return 1'b0;
	for (int j = 0; j < post_pkg::lanes; j++) begin
		sum = din[j];
		if (w0[post_pkg::bias_en_bit])
			sum = sum + bias[ch + j]; // 16-bit wrap
		v = sum;
		if (v < 0 && w0[post_pkg::relu_en_bit])
			v = w0[post_pkg::relu_leaky_bit] ? (v - step + 1) / step : 0; // floor division
		b = (v >>> post_pkg::narrow_lsb) & ((1 << kept) - 1);
		if (b >= (1 << (kept - 1)))
			b = b - (1 << kept);
		dout[j] = post_pkg::lane_t'(b);
	end
	return 1'b1;
endfunction

`endif

/* verif/tb_post_process.sv */
module tb_post_process;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned seed = 32'hdec0518e;
	localparam int wait_limit = 5000; // cycles per handshake or drain

	// flag bits of config word 0
	localparam logic [4:0] f_leaky = 5'(1 << post_pkg::relu_leaky_bit);
	localparam logic [4:0] f_bias = 5'(1 << post_pkg::bias_en_bit);
	localparam logic [4:0] f_sample = 5'(1 << post_pkg::sample_en_bit);
	localparam logic [4:0] f_relu = 5'(1 << post_pkg::relu_en_bit);
	localparam logic [4:0] f_row = 5'(1 << post_pkg::row_filter_bit);

	logic clk = 1'b0;
	logic rst_n;
	logic cfg_valid, cfg_ready;
	post_pkg::cfg_word_t cfg_data;
	logic bias_valid, bias_ready;
	post_pkg::lane_t bias_data;
	logic in_valid, in_ready;
	post_pkg::beat_t in_data;
	logic out_valid;
	logic out_ready = 1'b0;
	post_pkg::beat_t out_data;

	post_pkg::lane_t bias_tab [post_pkg::bias_depth];
	post_pkg::beat_t exp_q [$];
	bit stall_en = 1'b0;
	int out_total = 0;
	int data_errs = 0;
	int count_errs = 0;
	int other_errs = 0;

	`include "post_model.svh"

	post_process_top dut (.*);

	always #50 clk = ~clk;

	// sink stalls about one cycle in three
	always @(posedge clk)
		out_ready <= stall_en ? ($urandom % 3 != 0) : 1'b1;

	always @(posedge clk) begin
		if (out_valid && out_ready) begin
			out_total++;
			if (exp_q.size() == 0) begin
				$display("output beat %h arrived with none expected at %0t", out_data, $time);
				other_errs++;
			end else begin
				check_beat(exp_q.pop_front(), out_data);
			end
		end
	end

	task automatic check_beat(input post_pkg::beat_t exp, input post_pkg::beat_t got);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: beat %h, expected %h", $time, got, exp);
			data_errs++;
		end
	endtask

	task automatic check_count(input logic [post_pkg::len_w-1:0] exp,
			input logic [post_pkg::len_w-1:0] got);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %0d beats in frame, expected %0d", $time, got, exp);
			count_errs++;
		end
	endtask

	task automatic give_up(input string what);
		$display("no progress on %s after %0d cycles at %0t", what, wait_limit, $time);
		$display("errors: %0d data, %0d count, %0d other", data_errs, count_errs, other_errs);
		$display("Done: errors found");
		$finish;
	endtask

	// 0 cfg, 1 bias, 2 input, 3 output FIFO empty
	function automatic bit cond_met(input int what);
		case (what)
			0: return cfg_ready;
			1: return bias_ready;
			2: return in_ready;
			default: return !out_valid;
		endcase
	endfunction

	task automatic wait_for(input int what, input string name);
		int t;
		t = 0;
		do begin
			@(posedge clk);
			t++;
			if (t > wait_limit)
				give_up(name);
		end while (!cond_met(what));
	endtask

	task automatic run_frame(input logic [4:0] flags, input int w, input int h,
			input int chout, input int blocks, input bit stall);
		post_pkg::cfg_word_t cfg [post_pkg::cfg_words];
		post_pkg::beat_t in_q [$];
		post_pkg::beat_t din, dout;
		int pix, line, ch, n, n_exp, base, out_w, out_h;
		cfg[0] = 32'(flags) | (32'(chout * blocks) << post_pkg::o_ch_lsb);
		cfg[1] = (32'(h) << post_pkg::img_h_lsb) | (32'(w) << post_pkg::img_w_lsb);
		cfg[2] = (32'(blocks) << post_pkg::total_len_lsb) | (32'(chout) << post_pkg::chout_len_lsb);
		for (int i = 0; i < chout * blocks; i++)
			bias_tab[i] = post_pkg::lane_t'($urandom);
		// output beats per frame, first line dropped, even pixels and lines kept
		out_w = flags[post_pkg::sample_en_bit] ? (w + 1) / 2 : w;
		out_h = h - int'(flags[post_pkg::row_filter_bit]);
		if (flags[post_pkg::sample_en_bit])
			out_h = (out_h + 1) / 2;
		n_exp = out_w * (chout / post_pkg::lanes) * out_h * blocks;
		n = frame_beats(cfg[1], cfg[2]);
		for (int k = 0; k < n; k++) begin
			for (int j = 0; j < post_pkg::lanes; j++)
				din[j] = post_pkg::lane_t'($urandom);
			in_q.push_back(din);
			walk_pos(cfg[0], cfg[1], cfg[2], k, pix, line, ch);
			if (expect_beat(cfg[0], bias_tab, din, pix, line, ch, dout))
				exp_q.push_back(dout);
		end
		base = out_total;
		stall_en <= stall;
		cfg_valid <= 1'b1;
		foreach (cfg[i]) begin
			cfg_data <= cfg[i];
			wait_for(0, "configuration handshake");
		end
		cfg_valid <= 1'b0;
		bias_valid <= 1'b1;
		for (int i = 0; i < chout * blocks; i++) begin
			bias_data <= bias_tab[i];
			wait_for(1, "bias handshake");
		end
		bias_valid <= 1'b0;
		in_valid <= 1'b1;
		while (in_q.size() > 0) begin
			in_data <= in_q.pop_front();
			wait_for(2, "input handshake");
		end
		in_valid <= 1'b0;
		repeat (4) @(posedge clk); // pipeline latency, last beat now in the FIFO
		wait_for(3, "output FIFO drain");
		check_count(16'(n_exp), 16'(out_total - base));
		wait_for(0, "cfg_ready after frame");
	endtask

	initial begin
		void'($urandom(seed));
		rst_n <= 1'b0;
		cfg_valid <= 1'b0;
		cfg_data <= '0;
		bias_valid <= 1'b0;
		bias_data <= '0;
		in_valid <= 1'b0;
		in_data <= '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		run_frame(f_bias, 4, 3, 16, 2, 1'b0);
		run_frame(f_bias | f_relu, 3, 2, 8, 3, 1'b1);
		run_frame(f_bias | f_relu | f_leaky, 4, 2, 24, 1, 1'b0);
		run_frame(f_row, 4, 3, 16, 2, 1'b1);
		run_frame(f_sample | f_bias | f_relu, 5, 5, 8, 2, 1'b1);
		run_frame(f_row | f_sample | f_relu | f_leaky | f_bias, 3, 4, 16, 2, 1'b1);
		$display("errors: %0d data, %0d count, %0d other", data_errs, count_errs, other_errs);
		if (data_errs + count_errs + other_errs == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* design/post_process_top.sv */
module post_process_top (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 cfg_valid,
	output logic                 cfg_ready,
	input  post_pkg::cfg_word_t  cfg_data,

	input  logic                 bias_valid,
	output logic                 bias_ready,
	input  post_pkg::lane_t      bias_data,

	input  logic                 in_valid,
	output logic                 in_ready,
	input  post_pkg::beat_t      in_data,

	output logic                 out_valid,
	input  logic                 out_ready,
	output post_pkg::beat_t      out_data
);

	logic bias_we;
	logic [11:0] bias_wr_idx;
	post_pkg::bias_addr_t bias_rd_addr;
	post_pkg::beat_t bias_row;

	logic beat_fire, drop_line, keep_sample;
	logic bias_en, relu_en, relu_leaky, sample_en;

	logic wr_en;
	post_pkg::beat_t wr_data;
	logic almost_full;

	post_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.cfg_valid    (cfg_valid),
		.cfg_ready    (cfg_ready),
		.cfg_data     (cfg_data),
		.bias_valid   (bias_valid),
		.bias_ready   (bias_ready),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.almost_full  (almost_full),
		.bias_we      (bias_we),
		.bias_wr_idx  (bias_wr_idx),
		.bias_rd_addr (bias_rd_addr),
		.beat_fire    (beat_fire),
		.drop_line    (drop_line),
		.keep_sample  (keep_sample),
		.bias_en      (bias_en),
		.relu_en      (relu_en),
		.relu_leaky   (relu_leaky),
		.sample_en    (sample_en)
	);

	bias_cache u_bias_cache (
		.clk     (clk),
		.we      (bias_we),
		.wr_idx  (bias_wr_idx),
		.wr_data (bias_data),
		.rd_addr (bias_rd_addr),
		.rd_row  (bias_row)
	);

	// four stages, in transfer to fifo write
	post_pipeline u_pipeline (
		.clk         (clk),
		.rst_n       (rst_n),
		.beat_fire   (beat_fire),
		.in_data     (in_data),
		.drop_line   (drop_line),
		.keep_sample (keep_sample),
		.bias_row    (bias_row),
		.bias_en     (bias_en),
		.relu_en     (relu_en),
		.relu_leaky  (relu_leaky),
		.sample_en   (sample_en),
		.wr_en       (wr_en),
		.wr_data     (wr_data)
	);

	out_fifo u_out_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr_en       (wr_en),
		.wr_data     (wr_data),
		.rd_ready    (out_ready),
		.rd_valid    (out_valid),
		.rd_data     (out_data),
		.almost_full (almost_full) // throttles in_ready
	);

endmodule

/* design/out_fifo.sv */
module out_fifo (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             wr_en,
	input  post_pkg::beat_t  wr_data,
	input  logic             rd_ready,
	output logic             rd_valid,
	output post_pkg::beat_t  rd_data,
	output logic             almost_full
);

	logic [post_pkg::beat_w-1:0] mem [post_pkg::out_fifo_depth];
	logic [post_pkg::out_fifo_aw-1:0] wr_ptr, rd_ptr;
	logic [post_pkg::out_fifo_aw:0] count;
	logic do_wr, do_rd;

	assign do_wr = wr_en && (count < post_pkg::out_fifo_depth);
	assign do_rd = rd_valid && rd_ready;

	// head entry shows without a read request
	assign rd_valid = count != '0;
	assign rd_data = mem[rd_ptr];
	assign almost_full = (post_pkg::out_fifo_depth - count) < post_pkg::out_fifo_slack;

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* pipeline/post_pipeline.sv */
module post_pipeline (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             beat_fire,
	input  post_pkg::beat_t  in_data,
	input  logic             drop_line,
	input  logic             keep_sample,
	input  post_pkg::beat_t  bias_row,
	input  logic             bias_en,
	input  logic             relu_en,
	input  logic             relu_leaky,
	input  logic             sample_en,
	output logic             wr_en,
	output post_pkg::beat_t  wr_data
);

	logic s1_valid, s2_valid, s3_valid, s4_valid;
	logic s1_keep, s2_keep, s3_keep;
	post_pkg::beat_t s1_data, s2_data, s3_data, s4_data;

	// negative lanes only
	function automatic post_pkg::lane_t relu(input post_pkg::lane_t v, input logic leaky);
		if (v >= 0)
			return v;
		else if (leaky)
			return v >>> post_pkg::relu_shift;
		else
			return '0;
	endfunction

	// keep bits 11..4, sign extended
	function automatic post_pkg::lane_t narrow(input post_pkg::lane_t v);
		localparam int kept = post_pkg::narrow_msb - post_pkg::narrow_lsb + 1;
		return {{(post_pkg::lane_w - kept){v[post_pkg::narrow_msb]}},
			v[post_pkg::narrow_msb:post_pkg::narrow_lsb]};
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			s4_valid <= 1'b0;
		end else begin
			s1_valid <= beat_fire && !drop_line;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
			s4_valid <= s3_valid && (!sample_en || s3_keep);
		end
	end

	// sampling parity rides along with its beat
	always_ff @(posedge clk) begin
		s1_keep <= keep_sample;
		s2_keep <= s1_keep;
		s3_keep <= s2_keep;
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < post_pkg::lanes; i++) begin
			s1_data[i] <= drop_line ? '0 : in_data[i];
			// bias row lines up with stage 1, sum wraps at 16 bits
			s2_data[i] <= bias_en ? s1_data[i] + bias_row[i] : s1_data[i];
			s3_data[i] <= relu_en ? relu(s2_data[i], relu_leaky) : s2_data[i];
			s4_data[i] <= narrow(s3_data[i]);
		end
	end

	assign wr_en = s4_valid;
	assign wr_data = s4_data;

endmodule

/* design/bias_cache.sv */
module bias_cache (
	input  logic                  clk,
	input  logic                  we,
	input  logic [11:0]           wr_idx,
	input  post_pkg::lane_t       wr_data,
	input  post_pkg::bias_addr_t  rd_addr,
	output post_pkg::beat_t       rd_row
);

	// one bank per lane, bank j holds channels 8*row+j
	post_pkg::lane_t mem [post_pkg::lanes][post_pkg::bias_depth / post_pkg::lanes];

	always_ff @(posedge clk) begin
		if (we)
			mem[wr_idx[post_pkg::lane_sel_w-1:0]][wr_idx[post_pkg::bias_idx_w-1:post_pkg::lane_sel_w]]
				<= wr_data;
		for (int j = 0; j < post_pkg::lanes; j++)
			rd_row[j] <= mem[j][rd_addr]; // whole row each cycle
	end

endmodule

/* control/post_ctrl.sv */
module post_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cfg_valid,
	output logic                  cfg_ready,
	input  post_pkg::cfg_word_t   cfg_data,
	input  logic                  bias_valid,
	output logic                  bias_ready,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic                  almost_full,
	output logic                  bias_we,
	output logic [11:0]           bias_wr_idx,
	output post_pkg::bias_addr_t  bias_rd_addr,
	output logic                  beat_fire,
	output logic                  drop_line,
	output logic                  keep_sample,
	output logic                  bias_en,
	output logic                  relu_en,
	output logic                  relu_leaky,
	output logic                  sample_en
);

	post_pkg::ctrl_state_t state;

	logic [1:0] cfg_cnt;
	logic cfg_fire;
	logic row_filter;
	logic [post_pkg::len_w-1:0] o_ch;
	logic [post_pkg::dim_w-1:0] img_w, img_h;
	logic [post_pkg::len_w-1:0] chout_len, total_len;

	logic [post_pkg::len_w-1:0] bias_cnt;
	logic start_work;

	// walk position
	logic [post_pkg::dim_w-1:0] pix_cnt;
	logic signed [post_pkg::dim_w:0] line_cnt; // -1 marks the discarded first line
	logic [post_pkg::len_w-1:0] ch_cnt;
	logic [post_pkg::len_w-1:0] blk_base; // first channel of the current block
	logic [post_pkg::len_w-1:0] blk_cnt;
	logic pix_last, ch_last, line_last, blk_last;

	assign cfg_fire = cfg_valid && cfg_ready;
	assign bias_ready = (state == post_pkg::LOAD_BIAS) && (bias_cnt != o_ch);
	assign bias_we = bias_valid && bias_ready;
	assign bias_wr_idx = bias_cnt[post_pkg::bias_idx_w-1:0];
	assign start_work = (state == post_pkg::LOAD_BIAS) && (bias_cnt == o_ch);

	assign beat_fire = in_valid && in_ready;
	assign drop_line = line_cnt < 0;
	assign keep_sample = !pix_cnt[0] && !line_cnt[0];
	assign bias_rd_addr = ch_cnt[post_pkg::lane_sel_w +: $bits(post_pkg::bias_addr_t)];

	assign pix_last = {1'b0, pix_cnt} + 13'd1 >= {1'b0, img_w};
	assign ch_last = {1'b0, ch_cnt} + 17'd8 >= {1'b0, blk_base} + {1'b0, chout_len};
	// img_h lines per block, the filtered one included
	assign line_last = line_cnt + (row_filter ? 13'sd2 : 13'sd1) >= $signed({1'b0, img_h});
	assign blk_last = {1'b0, blk_cnt} + 17'd1 >= {1'b0, total_len};

	// config words in arrival order
	always_ff @(posedge clk) begin
		if (cfg_fire) begin
			case (cfg_cnt)
				2'd0: begin
					relu_leaky <= cfg_data[post_pkg::relu_leaky_bit];
					bias_en <= cfg_data[post_pkg::bias_en_bit];
					sample_en <= cfg_data[post_pkg::sample_en_bit];
					relu_en <= cfg_data[post_pkg::relu_en_bit];
					row_filter <= cfg_data[post_pkg::row_filter_bit];
					o_ch <= cfg_data[post_pkg::o_ch_lsb +: post_pkg::len_w];
				end
				2'd1: begin
					img_w <= cfg_data[post_pkg::img_w_lsb +: post_pkg::dim_w];
					img_h <= cfg_data[post_pkg::img_h_lsb +: post_pkg::dim_w];
				end
				2'd2: begin
					chout_len <= cfg_data[post_pkg::chout_len_lsb +: post_pkg::len_w];
					total_len <= cfg_data[post_pkg::total_len_lsb +: post_pkg::len_w];
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= post_pkg::IDLE;
			cfg_cnt <= '0;
			cfg_ready <= 1'b1;
			in_ready <= 1'b0;
			bias_cnt <= '0;
		end else begin
			case (state)
				post_pkg::IDLE: begin
					if (cfg_fire) begin
						cfg_cnt <= cfg_cnt + 2'd1;
						if (cfg_cnt == 2'(post_pkg::cfg_words - 1)) begin
							cfg_cnt <= '0;
							cfg_ready <= 1'b0;
							bias_cnt <= '0;
							state <= post_pkg::LOAD_BIAS;
						end
					end
				end
				post_pkg::LOAD_BIAS: begin
					if (bias_we)
						bias_cnt <= bias_cnt + 1'b1;
					if (start_work)
						state <= post_pkg::WORK; // also covers o_ch == 0
				end
				post_pkg::WORK: begin
					in_ready <= !almost_full;
					if (beat_fire && pix_last && ch_last && line_last && blk_last) begin
						in_ready <= 1'b0; // frame done
						cfg_ready <= 1'b1;
						state <= post_pkg::IDLE;
					end
				end
				default: state <= post_pkg::IDLE;
			endcase
		end
	end

	// pixels, then channel groups, then lines, then blocks
	always_ff @(posedge clk) begin
		if (!rst_n || start_work) begin
			pix_cnt <= '0;
			ch_cnt <= '0;
			blk_base <= '0;
			blk_cnt <= '0;
			line_cnt <= (rst_n && row_filter) ? -13'sd1 : 13'sd0;
		end else if (beat_fire) begin
			if (!pix_last) begin
				pix_cnt <= pix_cnt + 1'b1;
			end else begin
				pix_cnt <= '0;
				if (!ch_last) begin
					ch_cnt <= ch_cnt + 16'd8;
				end else if (!line_last) begin
					ch_cnt <= blk_base;
					line_cnt <= line_cnt + 13'sd1;
				end else begin
					line_cnt <= row_filter ? -13'sd1 : 13'sd0;
					blk_cnt <= blk_cnt + 1'b1;
					blk_base <= blk_base + chout_len;
					ch_cnt <= blk_base + chout_len; // next block start
				end
			end
		end
	end

endmodule

/* common/post_pkg.sv */
package post_pkg;

	// lane and beat geometry
	localparam int lane_w = 16;
	localparam int lanes = 8;
	localparam int beat_w = lane_w * lanes;
	localparam int lane_sel_w = $clog2(lanes);

	typedef logic signed [lane_w-1:0] lane_t;
	typedef lane_t [lanes-1:0] beat_t; // lane 0 in the low bits

	// configuration stream
	typedef logic [31:0] cfg_word_t;
	localparam int cfg_words = 3;

	// word 0
	localparam int relu_leaky_bit = 0;
	localparam int bias_en_bit = 1;
	localparam int sample_en_bit = 2;
	localparam int relu_en_bit = 3;
	localparam int row_filter_bit = 4;
	localparam int o_ch_lsb = 8;

	// word 1, image size
	localparam int img_w_lsb = 0;
	localparam int img_h_lsb = 12;
	localparam int dim_w = 12;

	// word 2, channel blocking
	localparam int chout_len_lsb = 0;
	localparam int total_len_lsb = 16;
	localparam int len_w = 16; // also the width of o_ch

	typedef enum logic [1:0] {
		IDLE,
		LOAD_BIAS,
		WORK
	} ctrl_state_t;

	// bias cache, one entry per output channel
	localparam int bias_depth = 4096;
	localparam int bias_idx_w = $clog2(bias_depth);
	typedef logic [bias_idx_w-lane_sel_w-1:0] bias_addr_t; // 512 rows of 8 channels

	// datapath constants
	localparam int relu_shift = 6;
	localparam int narrow_lsb = 4;
	localparam int narrow_msb = 11;

	// output buffering
	localparam int out_fifo_depth = 32;
	localparam int out_fifo_aw = $clog2(out_fifo_depth);
	localparam int out_fifo_slack = 8; // covers beats still in the pipeline

endpackage
